// File: Makefile
# Verilator simulation of the main-bus arbiter

VERILATOR ?= verilator
TOP       ?= mbus_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert
SIMFLAGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS SIMFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
	output logic MCLK,
	output logic reset
);

	localparam int RESET_CYCLES = 8;

	// 4 ns period
	initial begin
		MCLK = 1'b0;
		forever #2 MCLK = ~MCLK;
	end

	// Released on a falling edge after the reset cycles
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge MCLK);
		@(negedge MCLK);
		reset = 1'b0;
	end

endmodule

// File: bench/mbus_properties.sv
`timescale 1ns/1ps

module mbus_properties (
	input logic MCLK,
	input logic reset,
	input logic m68k_as_n,
	input logic m68k_dtack_n,
	input logic vbus_sel,
	input logic vbus_dtack_n,
	input logic rom_req,
	input logic rom_ack
);

	int failures = 0;

	// ----------------------------------------------------------
	// Acknowledge release
	// ----------------------------------------------------------
	m68k_release: assert property (@(posedge MCLK) disable iff (reset)
		$rose(m68k_as_n) |=> m68k_dtack_n)
		else begin
			$error("m68k_dtack_n still low one cycle after m68k_as_n rose");
			failures++;
		end

	vbus_release: assert property (@(posedge MCLK) disable iff (reset)
		$fell(vbus_sel) |=> vbus_dtack_n)
		else begin
			$error("vbus_dtack_n still low one cycle after vbus_sel fell");
			failures++;
		end

	// New ROM request only once the last one is answered
	rom_toggle: assert property (@(posedge MCLK) disable iff (reset)
		$changed(rom_req) |-> $past(rom_req) == $past(rom_ack))
		else begin
			$error("rom_req toggled while a ROM request was pending");
			failures++;
		end

	reset_acks: assert property (@(posedge MCLK)
		$past(reset) |-> m68k_dtack_n && vbus_dtack_n)
		else begin
			$error("acknowledge low during reset");
			failures++;
		end

endmodule

// File: bench/mbus_tb.sv
`timescale 1ns/1ps

module mbus_tb;

	localparam int TEST_COUNT      = 6;
	localparam int CYCLES_PER_TEST = 200;
	// Cartridge sizes in words
	localparam logic [23:0] ROMSZ_1MB = 24'h080000;
	localparam logic [23:0] ROMSZ_4MB = 24'h200000;

	logic        MCLK, reset;
	logic        m68k_as_n, m68k_rnw, m68k_uds_n, m68k_lds_n, m68k_dtack_n;
	logic [23:1] m68k_a, vbus_a, rom_addr, last_rom_addr;
	logic [15:0] m68k_do, m68k_di, vbus_data, rom_data, open_exp;
	logic        vbus_sel, vbus_dtack_n, rom_req, rom_ack;
	logic [23:0] romsz;
	logic        z80_busrq_n, z80_reset_n, z80_busak_n;
	integer      seed = 32'h060d_1847;
	int          error_count = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	clock_gen u_clock (.MCLK(MCLK), .reset(reset));

	mbus_system DUT (.*);

	bind mbus_system mbus_properties props (
		.MCLK         (MCLK),
		.reset        (reset),
		.m68k_as_n    (m68k_as_n),
		.m68k_dtack_n (m68k_dtack_n),
		.vbus_sel     (vbus_sel),
		.vbus_dtack_n (vbus_dtack_n),
		.rom_req      (rom_req),
		.rom_ack      (rom_ack)
	);

	// ----------------------------------------------------------
	// Compare tasks
	// ----------------------------------------------------------
	task automatic verify_word(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_rom_addr(input logic [23:1] got, input logic [23:1] exp);
		if (got !== exp) begin
			error_count++;
			$display("Error at %0d ns: rom_addr is %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic expect_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			error_count++;
			$display("Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic report_result(input string name, input int errors_at_start);
		tests_run++;
		if (error_count == errors_at_start) begin
			$display("Test %s: pass", name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d errors", name, error_count - errors_at_start);
		end
	endtask

	// ----------------------------------------------------------
	// Bus cycles on byte addresses
	// ----------------------------------------------------------
	task automatic m68k_read(input logic [23:0] byte_addr, output logic [15:0] data);
		@(negedge MCLK);
		m68k_a     = byte_addr[23:1];
		m68k_rnw   = 1'b1;
		m68k_uds_n = 1'b0;
		m68k_lds_n = 1'b0;
		m68k_as_n  = 1'b0;
		@(negedge MCLK);
		while (m68k_dtack_n) @(negedge MCLK);
		data       = m68k_di;
		m68k_as_n  = 1'b1;
		m68k_uds_n = 1'b1;
		m68k_lds_n = 1'b1;
		while (!m68k_dtack_n) @(negedge MCLK);
	endtask

	task automatic m68k_write(input logic [23:0] byte_addr, input logic [15:0] data,
			input logic uds_n, input logic lds_n);
		@(negedge MCLK);
		m68k_a     = byte_addr[23:1];
		m68k_do    = data;
		m68k_rnw   = 1'b0;
		m68k_uds_n = uds_n;
		m68k_lds_n = lds_n;
		m68k_as_n  = 1'b0;
		@(negedge MCLK);
		while (m68k_dtack_n) @(negedge MCLK);
		m68k_as_n  = 1'b1;
		m68k_rnw   = 1'b1;
		m68k_uds_n = 1'b1;
		m68k_lds_n = 1'b1;
		while (!m68k_dtack_n) @(negedge MCLK);
	endtask

	task automatic dma_read(input logic [23:0] byte_addr, output logic [15:0] data);
		@(negedge MCLK);
		vbus_a   = byte_addr[23:1];
		vbus_sel = 1'b1;
		@(negedge MCLK);
		while (vbus_dtack_n) @(negedge MCLK);
		data     = vbus_data;
		vbus_sel = 1'b0;
		while (!vbus_dtack_n) @(negedge MCLK);
	endtask

	// ROM data is the inverted low half of the word address it was asked for
	task automatic read_rom_and_check(input logic [23:0] bus_byte, input logic [23:0] rom_byte);
		logic [15:0] data;
		m68k_read(bus_byte, data);
		check_rom_addr(last_rom_addr, rom_byte[23:1]);
		verify_word("m68k_di", data, ~rom_byte[16:1]);
		open_exp = ~rom_byte[16:1];
	endtask

	// ----------------------------------------------------------
	// Directed tests
	// ----------------------------------------------------------
	task automatic reset_values();
		int e0;
		e0 = error_count;
		expect_level("m68k_dtack_n", m68k_dtack_n, 1'b1);
		expect_level("vbus_dtack_n", vbus_dtack_n, 1'b1);
		expect_level("z80_busrq_n", z80_busrq_n, 1'b1);
		expect_level("z80_reset_n", z80_reset_n, 1'b0);
		expect_level("rom_req", rom_req, rom_ack);
		report_result("reset state", e0);
	endtask

	task automatic ram_byte_merge();
		int          e0;
		logic [15:0] data;
		e0 = error_count;
		m68k_write(24'hFF0010, 16'h1234, 1'b0, 1'b0);
		m68k_write(24'hFF0010, 16'hAB00, 1'b0, 1'b1);
		m68k_read(24'hFF0010, data);
		verify_word("m68k_di", data, 16'hAB34);
		open_exp = 16'hAB34;
		report_result("work RAM", e0);
	endtask

	task automatic rom_linear_reads();
		int e0;
		e0 = error_count;
		read_rom_and_check(24'h000100, 24'h000100);
		read_rom_and_check(24'h012346, 24'h012346);
		read_rom_and_check(24'h3FFFFE, 24'h3FFFFE);
		report_result("ROM reads", e0);
	endtask

	task automatic rom_banking();
		int e0;
		e0 = error_count;
		// Small cartridge ignores the mapper
		@(negedge MCLK);
		romsz = ROMSZ_1MB;
		m68k_write(24'hA13002, 16'h0005, 1'b0, 1'b0);
		read_rom_and_check(24'h080000, 24'h080000);
		@(negedge MCLK);
		romsz = ROMSZ_4MB;
		m68k_write(24'hA13002, 16'h0005, 1'b0, 1'b0);
		// Page 5 starts at 280000
		read_rom_and_check(24'h080000, 24'h280000);
		read_rom_and_check(24'h000200, 24'h000200);
		report_result("banking", e0);
	endtask

	task automatic open_bus_and_zero();
		int          e0;
		logic [15:0] data;
		e0 = error_count;
		m68k_read(24'hA10000, data);
		verify_word("m68k_di", data, open_exp);
		@(negedge MCLK);
		romsz = ROMSZ_1MB;
		m68k_read(24'h200000, data);
		verify_word("m68k_di", data, 16'h0000);
		// A zero read is no memory read
		m68k_read(24'hA10000, data);
		verify_word("m68k_di", data, open_exp);
		@(negedge MCLK);
		romsz = ROMSZ_4MB;
		report_result("open bus", e0);
	endtask

	task automatic z80_control_and_dma();
		int          e0;
		logic [15:0] data;
		e0 = error_count;
		m68k_write(24'hA11100, 16'h0100, 1'b0, 1'b0);
		expect_level("z80_busrq_n", z80_busrq_n, 1'b0);
		m68k_write(24'hA11200, 16'h0100, 1'b0, 1'b0);
		expect_level("z80_reset_n", z80_reset_n, 1'b1);
		// Bit 8 follows z80_busak_n and the rest is open bus
		m68k_read(24'hA11100, data);
		verify_word("m68k_di", data, {open_exp[15:9], 1'b1, open_exp[7:0]});
		@(negedge MCLK);
		z80_busak_n = 1'b0;
		m68k_read(24'hA11100, data);
		verify_word("m68k_di", data, {open_exp[15:9], 1'b0, open_exp[7:0]});
		dma_read(24'hFF0010, data);
		verify_word("vbus_data", data, 16'hAB34);
		m68k_read(24'hA10000, data);
		verify_word("m68k_di", data, open_exp);
		report_result("control and DMA", e0);
	endtask

	// ----------------------------------------------------------
	// ROM model answering each toggle after 1 to 6 cycles
	// ----------------------------------------------------------
	initial begin : rom_model
		int delay;
		rom_ack  = 1'b0;
		rom_data = 16'h0000;
		@(negedge reset);
		forever begin
			@(negedge MCLK);
			if (rom_req !== rom_ack) begin
				delay = 1 + int'($unsigned($random(seed)) % 6);
				repeat (delay - 1) @(negedge MCLK);
				last_rom_addr = rom_addr;
				rom_data      = ~rom_addr[16:1];
				rom_ack       = rom_req;
			end
		end
	end

	initial begin : watchdog
		repeat (TEST_COUNT * CYCLES_PER_TEST + 16) @(posedge MCLK);
		$display("Timeout: tests did not finish within %0d cycles", TEST_COUNT * CYCLES_PER_TEST);
		$display("Done: errors found");
		$finish;
	end

	initial begin : main
		m68k_as_n   = 1'b1;
		m68k_a      = '0;
		m68k_do     = 16'h0000;
		m68k_rnw    = 1'b1;
		m68k_uds_n  = 1'b1;
		m68k_lds_n  = 1'b1;
		vbus_sel    = 1'b0;
		vbus_a      = '0;
		romsz       = ROMSZ_4MB;
		z80_busak_n = 1'b1;
		open_exp    = 16'h4E71;
		@(negedge reset);
		@(negedge MCLK);
		reset_values();
		ram_byte_merge();
		rom_linear_reads();
		rom_banking();
		open_bus_and_zero();
		z80_control_and_dma();
		$display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
			tests_run, tests_failed, error_count, DUT.props.failures);
		if (error_count == 0 && tests_failed == 0 && DUT.props.failures == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: source/mbus_decoder.sv
`timescale 1ns/1ps

module mbus_decoder (
	input  logic        MCLK,
	input  logic        reset,
	input  logic [23:0] romsz,
	mbus_txn_if.decoder txn
);
	import mbus_pkg::*;

	logic [BANK_BITS-1:0] bank [BANK_COUNT];
	logic                 bank_hit;
	logic                 ctrl_page;

	assign ctrl_page = (txn.addr[11:8] == CTRL_BUSREQ_PAGE) ||
	                   (txn.addr[11:8] == CTRL_RESET_PAGE);

	// ----------------------------------------------------------
	// Region decode
	// ----------------------------------------------------------
	always_comb begin
		if (txn.addr[23:20] < ROM_LIMIT_TOP) begin
			// Anything past the end of the cartridge reads as zero
			if ({1'b0, txn.addr} < romsz)
				txn.region = REG_ROM;
			else
				txn.region = REG_ROM_HIGH;
		end else if (txn.addr[23:8] == BANK_REG_PAGE) begin
			txn.region = REG_BANK;
		end else if (txn.addr[23:12] == CTRL_AREA && ctrl_page) begin
			txn.region = REG_CTRL;
		end else if (&txn.addr[23:21]) begin
			// E00000-FFFFFF, 64 KB mirrored
			txn.region = REG_RAM;
		end else begin
			txn.region = REG_OPEN;
		end
	end

	// ----------------------------------------------------------
	// Mapper bank registers
	// ----------------------------------------------------------
	// Register 0 is fixed, only large carts use the mapper
	assign bank_hit = txn.wr_stb && (txn.region == REG_BANK) &&
	                  (|txn.addr[3:1]) && (romsz > BANKING_MIN_ROMSZ);

	always_ff @(posedge MCLK) begin
		if (reset) begin
			for (int i = 0; i < BANK_COUNT; i++) begin
				bank[i] <= BANK_BITS'(i);
			end
			txn.bank_en <= 1'b0;
		end else if (bank_hit) begin
			bank[txn.addr[3:1]] <= txn.wdata[BANK_BITS-1:0];
			txn.bank_en         <= 1'b1;
		end
	end

	// 512 KB pages picked by address bits 21 to 19
	assign txn.rom_addr = txn.bank_en ? {bank[txn.addr[21:19]], txn.addr[18:1]}
	                                  : txn.addr;

endmodule

// File: source/mbus_pkg.sv
package mbus_pkg;

	// ----------------------------------------------------------
	// Bus state machine and ownership
	// ----------------------------------------------------------
	typedef enum logic [3:0] {
		ST_IDLE,
		ST_SELECT,
		ST_RAM_READ,
		ST_ROM_READ,
		ST_FINISH
	} mbus_state_t;

	typedef enum logic [1:0] {
		SRC_NONE,
		SRC_M68K,
		SRC_VDP
	} mbus_src_t;

	// Decoded target of the latched address
	typedef enum logic [2:0] {
		REG_ROM,
		REG_ROM_HIGH,
		REG_BANK,
		REG_CTRL,
		REG_RAM,
		REG_OPEN
	} region_t;

	// ----------------------------------------------------------
	// Address map
	// ----------------------------------------------------------
	// NOP opcode, what the 68000 sees on an unmapped read after reset
	localparam logic [15:0] OPEN_BUS_RESET = 16'h4E71;

	localparam int BANK_COUNT    = 8;
	localparam int BANK_BITS     = 5;
	localparam int RAM_ADDR_BITS = 15;

	// romsz counts 16-bit words, so 2 MB is 1M words
	localparam logic [23:0] BANKING_MIN_ROMSZ = 24'h100000;

	// ROM space is 000000-9FFFFF
	localparam logic [3:0] ROM_LIMIT_TOP = 4'hA;

	// Mapper registers at A130xx, Z80 control at A111xx and A112xx
	localparam logic [15:0] BANK_REG_PAGE    = 16'hA130;
	localparam logic [11:0] CTRL_AREA        = 12'hA11;
	localparam logic [3:0]  CTRL_BUSREQ_PAGE = 4'h1;
	localparam logic [3:0]  CTRL_RESET_PAGE  = 4'h2;

endpackage

// File: source/mbus_responder.sv
`timescale 1ns/1ps

module mbus_responder (
	input  logic             MCLK,
	input  logic             reset,
	input  logic             m68k_as_n,
	input  logic             vbus_sel,
	output logic [15:0]      m68k_di,
	output logic             m68k_dtack_n,
	output logic [15:0]      vbus_data,
	output logic             vbus_dtack_n,
	mbus_result_if.responder res
);
	import mbus_pkg::*;

	logic [15:0] word;

	// Open-bus substitution for unmapped and bank register reads
	assign word = res.use_open ? res.open_word : res.data;

	// ----------------------------------------------------------
	// Acknowledges and open-bus word
	// ----------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			m68k_dtack_n  <= 1'b1;
			vbus_dtack_n  <= 1'b1;
			res.open_word <= OPEN_BUS_RESET;
		end else begin
			if (m68k_as_n)
				m68k_dtack_n <= 1'b1;
			if (!vbus_sel)
				vbus_dtack_n <= 1'b1;

			if (res.done) begin
				if (res.store_open)
					res.open_word <= res.data;
				unique case (res.src)
				SRC_M68K: m68k_dtack_n <= 1'b0;
				SRC_VDP:  vbus_dtack_n <= 1'b0;
				default:  ;
				endcase
			end
		end
	end

	// Read data toward each requester
	always_ff @(posedge MCLK) begin
		if (res.done) begin
			if (res.src == SRC_M68K)
				m68k_di <= word;
			if (res.src == SRC_VDP)
				vbus_data <= word;
		end
	end

endmodule

// File: source/mbus_result_if.sv
`timescale 1ns/1ps

interface mbus_result_if;
	import mbus_pkg::*;

	// One-cycle completion from the sequencer
	logic        done;
	mbus_src_t   src;
	logic [15:0] data;
	logic        use_open;
	logic        store_open;

	// Last word the 68000 read from memory
	logic [15:0] open_word;

	modport sequencer (
		output done, src, data, use_open, store_open,
		input  open_word
	);

	modport responder (
		input  done, src, data, use_open, store_open,
		output open_word
	);

endinterface

// File: source/mbus_sequencer.sv
`timescale 1ns/1ps

module mbus_sequencer (
	input  logic             MCLK,
	input  logic             reset,
	input  logic             m68k_as_n,
	input  logic [23:1]      m68k_a,
	input  logic [15:0]      m68k_do,
	input  logic             m68k_rnw,
	input  logic             m68k_uds_n,
	input  logic             m68k_lds_n,
	input  logic             m68k_dtack_n,
	input  logic             vbus_sel,
	input  logic [23:1]      vbus_a,
	input  logic             vbus_dtack_n,
	output logic             rom_req,
	input  logic             rom_ack,
	input  logic [15:0]      rom_data,
	input  logic             z80_busak_n,
	output logic             z80_busrq_n,
	output logic             z80_reset_n,
	mbus_txn_if.sequencer    txn,
	mbus_result_if.sequencer res
);
	import mbus_pkg::*;

	mbus_state_t              state;
	logic                     fin_wait;
	logic [RAM_ADDR_BITS-1:0] ram_addr;
	logic [15:0]              ram [2**RAM_ADDR_BITS];
	logic                     ctrl_bit;
	logic                     m68k_mem_read;

	assign txn.wr_stb    = (state == ST_SELECT) && !txn.rnw;
	assign ram_addr      = txn.addr[RAM_ADDR_BITS:1];
	assign ctrl_bit      = (txn.addr[11:8] == CTRL_BUSREQ_PAGE) ? z80_busak_n : z80_reset_n;
	assign m68k_mem_read = (txn.src == SRC_M68K) && txn.rnw;

	// Work RAM with byte lanes
	always_ff @(posedge MCLK) begin
		if (txn.wr_stb && txn.region == REG_RAM) begin
			if (!txn.uds_n)
				ram[ram_addr][15:8] <= txn.wdata[15:8];
			if (!txn.lds_n)
				ram[ram_addr][7:0] <= txn.wdata[7:0];
		end
	end

	// ----------------------------------------------------------
	// Bus state machine
	// ----------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state          <= ST_IDLE;
			fin_wait       <= 1'b0;
			rom_req        <= rom_ack;
			z80_busrq_n    <= 1'b1;
			z80_reset_n    <= 1'b0;
			txn.src        <= SRC_NONE;
			res.src        <= SRC_NONE;
			res.done       <= 1'b0;
			res.use_open   <= 1'b0;
			res.store_open <= 1'b0;
		end else begin
			res.done <= 1'b0;

			unique case (state)
			ST_IDLE: begin
				fin_wait       <= 1'b0;
				res.use_open   <= 1'b0;
				res.store_open <= 1'b0;
				// Skip the cycle where the last acknowledge is still on its way
				if (!res.done) begin
					if (!m68k_as_n && m68k_dtack_n) begin
						txn.src   <= SRC_M68K;
						res.src   <= SRC_M68K;
						txn.addr  <= m68k_a;
						txn.wdata <= m68k_do;
						txn.rnw   <= m68k_rnw;
						txn.uds_n <= m68k_uds_n;
						txn.lds_n <= m68k_lds_n;
						state     <= ST_SELECT;
					end else if (vbus_sel && vbus_dtack_n) begin
						txn.src   <= SRC_VDP;
						res.src   <= SRC_VDP;
						txn.addr  <= vbus_a;
						txn.wdata <= '0;
						txn.rnw   <= 1'b1;
						txn.uds_n <= 1'b0;
						txn.lds_n <= 1'b0;
						state     <= ST_SELECT;
					end
				end
			end

			ST_SELECT: begin
				state <= ST_FINISH;
				unique case (txn.region)
				REG_ROM: begin
					if (txn.rnw) begin
						rom_req <= ~rom_ack;
						state   <= ST_ROM_READ;
					end
				end
				REG_ROM_HIGH: res.data <= '0;
				REG_CTRL: begin
					res.data <= {res.open_word[15:9], ctrl_bit, res.open_word[7:0]};
					if (txn.wr_stb && !txn.uds_n) begin
						if (txn.addr[11:8] == CTRL_BUSREQ_PAGE)
							z80_busrq_n <= ~txn.wdata[8];
						if (txn.addr[11:8] == CTRL_RESET_PAGE)
							z80_reset_n <= txn.wdata[8];
					end
				end
				REG_RAM: state <= ST_RAM_READ;
				default: res.use_open <= 1'b1;
				endcase
			end

			ST_RAM_READ: begin
				res.data       <= ram[ram_addr];
				res.store_open <= m68k_mem_read;
				state          <= ST_FINISH;
			end

			// A slow ROM holds the whole bus here
			ST_ROM_READ: begin
				if (rom_req == rom_ack) begin
					res.data       <= rom_data;
					res.store_open <= m68k_mem_read;
					state          <= ST_FINISH;
				end
			end

			ST_FINISH: begin
				if (!fin_wait) begin
					res.done <= 1'b1;
					fin_wait <= 1'b1;
				end
				// 68000 reads hold the bus until the strobe goes away
				if (txn.src != SRC_M68K || !txn.rnw || (fin_wait && m68k_as_n))
					state <= ST_IDLE;
			end

			default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: source/mbus_system.sv
`timescale 1ns/1ps

module mbus_system (
	input  logic        MCLK,
	input  logic        reset,

	// 68000
	input  logic        m68k_as_n,
	input  logic [23:1] m68k_a,
	input  logic [15:0] m68k_do,
	input  logic        m68k_rnw,
	input  logic        m68k_uds_n,
	input  logic        m68k_lds_n,
	output logic [15:0] m68k_di,
	output logic        m68k_dtack_n,

	// Video DMA
	input  logic        vbus_sel,
	input  logic [23:1] vbus_a,
	output logic [15:0] vbus_data,
	output logic        vbus_dtack_n,

	// Cartridge ROM, size in words
	output logic [23:1] rom_addr,
	output logic        rom_req,
	input  logic [15:0] rom_data,
	input  logic        rom_ack,
	input  logic [23:0] romsz,

	// Z80 control
	output logic        z80_busrq_n,
	output logic        z80_reset_n,
	input  logic        z80_busak_n
);

	mbus_txn_if    txn ();
	mbus_result_if res ();

	assign rom_addr = txn.rom_addr;

	mbus_decoder u_decoder (
		.MCLK  (MCLK),
		.reset (reset),
		.romsz (romsz),
		.txn   (txn)
	);

	mbus_sequencer u_sequencer (
		.MCLK         (MCLK),
		.reset        (reset),
		.m68k_as_n    (m68k_as_n),
		.m68k_a       (m68k_a),
		.m68k_do      (m68k_do),
		.m68k_rnw     (m68k_rnw),
		.m68k_uds_n   (m68k_uds_n),
		.m68k_lds_n   (m68k_lds_n),
		.m68k_dtack_n (m68k_dtack_n),
		.vbus_sel     (vbus_sel),
		.vbus_a       (vbus_a),
		.vbus_dtack_n (vbus_dtack_n),
		.rom_req      (rom_req),
		.rom_ack      (rom_ack),
		.rom_data     (rom_data),
		.z80_busak_n  (z80_busak_n),
		.z80_busrq_n  (z80_busrq_n),
		.z80_reset_n  (z80_reset_n),
		.txn          (txn),
		.res          (res)
	);

	mbus_responder u_responder (
		.MCLK         (MCLK),
		.reset        (reset),
		.m68k_as_n    (m68k_as_n),
		.vbus_sel     (vbus_sel),
		.m68k_di      (m68k_di),
		.m68k_dtack_n (m68k_dtack_n),
		.vbus_data    (vbus_data),
		.vbus_dtack_n (vbus_dtack_n),
		.res          (res)
	);

endmodule

// File: source/mbus_txn_if.sv
`timescale 1ns/1ps

interface mbus_txn_if;
	import mbus_pkg::*;

	// Latched by the sequencer when a request is taken
	logic [23:1] addr;
	logic [15:0] wdata;
	logic        rnw;
	logic        uds_n;
	logic        lds_n;
	mbus_src_t   src;
	logic        wr_stb;

	// Decode results, combinational on the fields above
	region_t     region;
	logic [23:1] rom_addr;
	logic        bank_en;

	modport sequencer (
		output addr, wdata, rnw, uds_n, lds_n, src, wr_stb,
		input  region
	);

	modport decoder (
		input  addr, wdata, wr_stb,
		output region, rom_addr, bank_en
	);

endinterface

// File: verilog.f
source/mbus_pkg.sv
source/mbus_txn_if.sv
source/mbus_result_if.sv
source/mbus_decoder.sv
source/mbus_sequencer.sv
source/mbus_responder.sv
source/mbus_system.sv
bench/clock_gen.sv
bench/mbus_properties.sv
bench/mbus_tb.sv
